// ==== eth_rx_macros.svh ====
`ifndef ETH_RX_MACROS_SVH
`define ETH_RX_MACROS_SVH

//////////////////////
// Packet FIFO geometry

// Address width of the crossing FIFO
// 1024 words holds a couple of full size frames
`define ETH_RX_FIFO_AW 10

// Number of words in the FIFO memory
`define ETH_RX_FIFO_DEPTH (1 << `ETH_RX_FIFO_AW)

//////////////////////
// Stored word layout

// 3 bytes-valid bits on top of 32 data bits
// A bytes-valid field of zero is a frame delimiter
`define ETH_RX_WORD_W 35

`endif

// ==== eth_frame_pkg.sv ====
package eth_frame_pkg;

	//////////////////////
	// MAC side, rx_clk domain

	// Frame strobes exactly as the MAC produces them
	typedef struct packed {
		// Pulses once before the first data word
		logic		start;
		// Qualifies bytes_valid and data
		logic		data_valid;
		// 1 to 4 valid bytes, left aligned in data
		logic [2:0]	bytes_valid;
		logic [31:0]	data;
		// Frame is good, keep it
		logic		commit;
		// Frame is bad, throw it away
		logic		drop;
	} mac_rx_bus_t;

	//////////////////////
	// System side, sys_clk domain

	// Same strobes without drop
	// Only committed frames ever show up here
	typedef struct packed {
		logic		start;
		logic		data_valid;
		logic [2:0]	bytes_valid;
		logic [31:0]	data;
		// One cycle after the last data word
		logic		commit;
	} sys_rx_bus_t;

endpackage

// ==== cdc_fifo_pkg.sv ====
`include "eth_rx_macros.svh"

package cdc_fifo_pkg;

	//////////////////////
	// Stored word

	// bytes_valid of zero marks the delimiter in front of each frame
	typedef struct packed {
		logic [2:0]	bytes_valid;
		logic [31:0]	data;
	} fifo_word_t;

	//////////////////////
	// Write side command, rx_clk domain

	// A rollback together with a write discards first, then writes
	// A commit together with a write writes first, then commits
	typedef struct packed {
		logic		wr_en;
		fifo_word_t	word;
		logic		commit;
		logic		rollback;
	} fifo_wr_cmd_t;

	//////////////////////
	// Read side status, sys_clk domain

	typedef struct packed {
		// Committed words not yet popped
		logic [`ETH_RX_FIFO_AW:0]	size;
		// Registered read data
		fifo_word_t			word;
	} fifo_rd_status_t;

endpackage

// ==== rx_word_packer.sv ====
`timescale 1ns/1ns

module rx_word_packer (
	input  logic				rx_clk,
	input  logic				wr_rst,
	input  eth_frame_pkg::mac_rx_bus_t	mac,
	output cdc_fifo_pkg::fifo_wr_cmd_t	cmd
);
	import cdc_fifo_pkg::*;

	// High between start and commit or drop
	logic		in_frame;
	// Word to store this cycle
	fifo_word_t	in_word;

	// Start always stores a delimiter, otherwise the MAC word
	always_comb begin
		if (mac.start) begin
			in_word = '0;
		end else begin
			in_word = '{bytes_valid: mac.bytes_valid, data: mac.data};
		end
	end

	//////////////////////
	// Command register

	always_ff @(posedge rx_clk) begin
		if (wr_rst) begin
			cmd		<= '0;
			in_frame	<= 1'b0;
		end else begin
			// Delimiter on start, data only inside an open frame
			cmd.wr_en	<= mac.start | (mac.data_valid & in_frame);
			cmd.word	<= in_word;

			// A start that wins over commit leaves the frame to the rollback below
			cmd.commit	<= mac.commit & in_frame & ~mac.start;

			// Drop, or a new start cutting off a frame that never ended
			cmd.rollback	<= in_frame & (mac.drop | mac.start);

			// Track frame boundaries
			if (mac.start) begin
				in_frame <= 1'b1;
			end else if (mac.commit | mac.drop) begin
				in_frame <= 1'b0;
			end
		end
	end

endmodule

// ==== packet_cdc_fifo.sv ====
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module packet_cdc_fifo (
	input  logic				rx_clk,
	input  logic				sys_clk,
	input  logic				rst,
	output logic				wr_rst,
	input  cdc_fifo_pkg::fifo_wr_cmd_t	cmd,
	input  logic				rd_en,
	input  logic				pop,
	output cdc_fifo_pkg::fifo_rd_status_t	status
);
	import cdc_fifo_pkg::*;

	// Binary to Gray
	function automatic logic [`ETH_RX_FIFO_AW:0] bin2gray(input logic [`ETH_RX_FIFO_AW:0] b);
		return b ^ (b >> 1);
	endfunction

	// Gray to binary, walking down from the MSB
	function automatic logic [`ETH_RX_FIFO_AW:0] gray2bin(input logic [`ETH_RX_FIFO_AW:0] g);
		logic [`ETH_RX_FIFO_AW:0] b;
		b[`ETH_RX_FIFO_AW] = g[`ETH_RX_FIFO_AW];
		for (int i = `ETH_RX_FIFO_AW - 1; i >= 0; i--) begin
			b[i] = b[i + 1] ^ g[i];
		end
		return b;
	endfunction

	// Word storage
	logic [`ETH_RX_WORD_W-1:0]	mem [`ETH_RX_FIFO_DEPTH];

	// Write domain state
	logic [1:0]			rst_pipe;
	logic [`ETH_RX_FIFO_AW:0]	wr_ptr;
	logic [`ETH_RX_FIFO_AW:0]	commit_ptr;
	logic [`ETH_RX_FIFO_AW:0]	commit_gray;
	logic				overflow;
	logic [`ETH_RX_FIFO_AW:0]	rd_sync1;
	logic [`ETH_RX_FIFO_AW:0]	rd_sync2;

	// Write domain decode
	logic [`ETH_RX_FIFO_AW:0]	rd_ptr_w;
	logic [`ETH_RX_FIFO_AW:0]	wr_base;
	logic [`ETH_RX_FIFO_AW:0]	wr_next;
	logic [`ETH_RX_FIFO_AW:0]	fill;
	logic				full;
	logic				ovf_now;
	logic				ovf_hit;
	logic				do_wr;

	// Read domain state
	logic [`ETH_RX_FIFO_AW:0]	rd_ptr;
	logic [`ETH_RX_FIFO_AW:0]	rd_gray;
	logic [`ETH_RX_FIFO_AW:0]	cm_sync1;
	logic [`ETH_RX_FIFO_AW:0]	cm_sync2;
	fifo_word_t			rd_data;

	//////////////////////
	// Reset into rx_clk

	always_ff @(posedge rx_clk) begin
		rst_pipe <= {rst_pipe[0], rst};
	end

	assign wr_rst = rst_pipe[1];

	//////////////////////
	// Write side

	// Read pointer as seen from rx_clk, lags the real one
	assign rd_ptr_w = gray2bin(rd_sync2);

	always_comb begin
		// Rollback rewinds before anything is written this cycle
		wr_base = cmd.rollback ? commit_ptr : wr_ptr;
		fill	= wr_base - rd_ptr_w;
		// Pointers are one bit wider than the address, so MSB of fill means full
		full	= fill[`ETH_RX_FIFO_AW];

		// Frame already overflowed, ignore the rest of it
		ovf_now = overflow & ~cmd.rollback;
		do_wr	= cmd.wr_en & ~full & ~ovf_now;
		// This write is the one that did not fit
		ovf_hit = cmd.wr_en & full;
		wr_next = wr_base + (`ETH_RX_FIFO_AW + 1)'(do_wr);
	end

	always_ff @(posedge rx_clk) begin
		if (do_wr) begin
			mem[wr_base[`ETH_RX_FIFO_AW-1:0]] <= cmd.word;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (wr_rst) begin
			wr_ptr		<= '0;
			commit_ptr	<= '0;
			commit_gray	<= '0;
			overflow	<= 1'b0;
			rd_sync1	<= '0;
			rd_sync2	<= '0;
		end else begin
			// Gray copy is registered so only clean codes leave this domain
			commit_gray	<= bin2gray(commit_ptr);
			rd_sync1	<= rd_gray;
			rd_sync2	<= rd_sync1;

			if (cmd.commit && !cmd.rollback) begin
				// Overflowed frame: commit behaves as a rollback
				if (ovf_now || ovf_hit) begin
					wr_ptr <= commit_ptr;
				end else begin
					wr_ptr		<= wr_next;
					commit_ptr	<= wr_next;
				end
				overflow <= 1'b0;
			end else begin
				wr_ptr		<= wr_next;
				overflow	<= ovf_now | ovf_hit;
			end
		end
	end

	//////////////////////
	// Read side

	// Registered read, data is there one edge after rd_en is seen
	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_ptr[`ETH_RX_FIFO_AW-1:0]];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			rd_ptr		<= '0;
			rd_gray		<= '0;
			cm_sync1	<= '0;
			cm_sync2	<= '0;
		end else begin
			rd_ptr		<= rd_ptr + (`ETH_RX_FIFO_AW + 1)'(pop);
			rd_gray		<= bin2gray(rd_ptr);
			cm_sync1	<= commit_gray;
			cm_sync2	<= cm_sync1;
		end
	end

	// Only committed words count toward size
	assign status.size = gray2bin(cm_sync2) - rd_ptr;
	assign status.word = rd_data;

endmodule

// ==== rx_frame_unpacker.sv ====
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module rx_frame_unpacker (
	input  logic				sys_clk,
	input  logic				rst,
	input  cdc_fifo_pkg::fifo_rd_status_t	status,
	output logic				rd_en,
	output logic				pop,
	output eth_frame_pkg::sys_rx_bus_t	frame,
	output logic [63:0]			perf_rx_cdc_frames
);
	import cdc_fifo_pkg::*;

	typedef enum logic [2:0] {
		ST_HDR_WAIT,
		ST_HDR_READ,
		ST_HDR_CHECK,
		ST_IDLE,
		ST_PACKET,
		ST_RESTART,
		ST_HELD
	} state_t;

	state_t				state;
	// Read issued two edges ago, its data is on status.word now
	logic				rd_d1;
	// Committed words not yet requested
	logic [`ETH_RX_FIFO_AW:0]	avail;
	logic				more;
	fifo_word_t			word;
	logic				is_delim;
	logic				load_word;

	// Output bus registers
	logic				start_q;
	logic				dv_q;
	logic				commit_q;
	logic [2:0]			bv_q;
	logic [31:0]			data_q;

	// The last pop has not reached the FIFO pointer yet
	assign avail	= status.size - (`ETH_RX_FIFO_AW + 1)'(pop);
	assign more	= (avail != '0);
	assign word	= status.word;
	assign is_delim	= (word.bytes_valid == 3'd0);

	// Capture a data word, or the first word after a back-to-back delimiter
	assign load_word = rd_d1 & ((state == ST_PACKET & ~is_delim) | (state == ST_RESTART));

	//////////////////////
	// Pop FSM

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state			<= ST_HDR_WAIT;
			rd_en			<= 1'b0;
			pop			<= 1'b0;
			rd_d1			<= 1'b0;
			start_q			<= 1'b0;
			dv_q			<= 1'b0;
			commit_q		<= 1'b0;
			perf_rx_cdc_frames	<= '0;
		end else begin
			// Strobes default low
			rd_en		<= 1'b0;
			pop		<= 1'b0;
			start_q		<= 1'b0;
			dv_q		<= 1'b0;
			commit_q	<= 1'b0;
			rd_d1		<= rd_en;

			case (state)
				// Fetch the delimiter of the next frame
				ST_HDR_WAIT: begin
					if (more) begin
						rd_en	<= 1'b1;
						pop	<= 1'b1;
						state	<= ST_HDR_READ;
					end
				end

				ST_HDR_READ: begin
					state <= ST_HDR_CHECK;
				end

				// Anything but a delimiter is junk, drop it and look again
				ST_HDR_CHECK: begin
					state <= is_delim ? ST_IDLE : ST_HDR_WAIT;
				end

				// Header consumed, start once the frame body is visible
				ST_IDLE: begin
					if (more) begin
						start_q	<= 1'b1;
						rd_en	<= 1'b1;
						pop	<= 1'b1;
						state	<= ST_PACKET;
					end
				end

				// Up to two reads in flight, one word per cycle
				ST_PACKET: begin
					if (rd_d1 && is_delim) begin
						// Next frame's header, this one is done
						commit_q		<= 1'b1;
						perf_rx_cdc_frames	<= perf_rx_cdc_frames + 64'd1;
						// A read already in flight belongs to the next frame
						state <= rd_en ? ST_RESTART : ST_IDLE;
					end else if (rd_d1 || more || rd_en) begin
						dv_q <= rd_d1;
						if (more) begin
							rd_en	<= 1'b1;
							pop	<= 1'b1;
						end
					end else begin
						// Nothing left and nothing pending, frame ends here
						commit_q		<= 1'b1;
						perf_rx_cdc_frames	<= perf_rx_cdc_frames + 64'd1;
						state			<= ST_HDR_WAIT;
					end
				end

				// First word of a back-to-back frame, hold it behind start
				ST_RESTART: begin
					if (is_delim) begin
						// Empty frame, treat it as a header
						state <= ST_IDLE;
					end else begin
						start_q	<= 1'b1;
						state	<= ST_HELD;
						if (more) begin
							rd_en	<= 1'b1;
							pop	<= 1'b1;
						end
					end
				end

				// Release the held word, keep the pipe going
				ST_HELD: begin
					dv_q	<= 1'b1;
					state	<= ST_PACKET;
					if (more) begin
						rd_en	<= 1'b1;
						pop	<= 1'b1;
					end
				end

				default: begin
					state <= ST_HDR_WAIT;
				end
			endcase
		end
	end

	// Payload only
	always_ff @(posedge sys_clk) begin
		if (load_word) begin
			bv_q	<= word.bytes_valid;
			data_q	<= word.data;
		end
	end

	assign frame = '{
		start:		start_q,
		data_valid:	dv_q,
		bytes_valid:	bv_q,
		data:		data_q,
		commit:		commit_q
	};

endmodule

// ==== eth_rx_cdc.sv ====
`timescale 1ns/1ns

module eth_rx_cdc (
	input  logic				rx_clk,
	input  logic				sys_clk,
	input  logic				rst,
	input  eth_frame_pkg::mac_rx_bus_t	mac,
	output eth_frame_pkg::sys_rx_bus_t	frame,
	output logic [63:0]			perf_rx_cdc_frames
);
	import cdc_fifo_pkg::*;

	// rst after the rx_clk synchronizer
	logic			wr_rst;
	// Packer to FIFO, one command per rx_clk
	fifo_wr_cmd_t		cmd;
	// FIFO to unpacker
	fifo_rd_status_t	status;
	logic			rd_en;
	logic			pop;

	//////////////////////
	// rx_clk domain

	rx_word_packer packer0 (
		.rx_clk	(rx_clk),
		.wr_rst	(wr_rst),
		.mac	(mac),
		.cmd	(cmd)
	);

	// Crossing point
	packet_cdc_fifo fifo0 (
		.rx_clk	(rx_clk),
		.sys_clk(sys_clk),
		.rst	(rst),
		.wr_rst	(wr_rst),
		.cmd	(cmd),
		.rd_en	(rd_en),
		.pop	(pop),
		.status	(status)
	);

	//////////////////////
	// sys_clk domain

	rx_frame_unpacker unpacker0 (
		.sys_clk		(sys_clk),
		.rst			(rst),
		.status			(status),
		.rd_en			(rd_en),
		.pop			(pop),
		.frame			(frame),
		.perf_rx_cdc_frames	(perf_rx_cdc_frames)
	);

endmodule

// ==== eth_rx_cdc_chk.sv ====
`timescale 1ns/1ns

module eth_rx_cdc_chk (
	input  logic				sys_clk,
	input  logic				rst,
	input  eth_frame_pkg::sys_rx_bus_t	frame
);
	// Set by start, cleared by commit
	logic	open_q;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			open_q <= 1'b0;
		end else if (frame.start) begin
			open_q <= 1'b1;
		end else if (frame.commit) begin
			open_q <= 1'b0;
		end
	end

	//////////////////////
	// System bus protocol

	// Data words only between start and commit
	data_in_frame: assert property (@(posedge sys_clk) disable iff (rst)
		frame.data_valid |-> open_q)
		else $error("data_valid seen outside a frame");

	// Every commit closes a frame that was started
	commit_after_start: assert property (@(posedge sys_clk) disable iff (rst)
		frame.commit |-> open_q)
		else $error("commit seen without a start");

	// Start and commit never share a cycle
	start_commit_apart: assert property (@(posedge sys_clk) disable iff (rst)
		!(frame.start && frame.commit))
		else $error("start and commit high together");

endmodule

// ==== tb_eth_rx_cdc.sv ====
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module tb_eth_rx_cdc;
	import eth_frame_pkg::*;

	// Frame endings on the MAC bus
	localparam int END_COMMIT	= 0;
	localparam int END_DROP		= 1;
	localparam int END_NONE		= 2;

	// Frames per test
	localparam int N_RAND	= 40;
	localparam int N_DROP	= 12;
	localparam int N_OVF	= 5;
	localparam int N_B2B	= 10;
	localparam int N_FRAMES	= N_RAND + N_DROP + N_OVF + N_B2B;
	// Second frame of the overflow test is too big for the FIFO
	localparam int BIG_IDX	= N_RAND + N_DROP + 1;
	localparam int BIG_LEN	= 1100;

	// One data word as seen on either bus
	typedef struct packed {
		logic [2:0]	bytes_valid;
		logic [31:0]	data;
	} beat_t;

	logic		rx_clk;
	logic		sys_clk;
	logic		rst;
	mac_rx_bus_t	mac;
	sys_rx_bus_t	frame;
	logic [63:0]	perf_rx_cdc_frames;

	integer		seed;
	int		len_tab [N_FRAMES];
	int		frame_idx;
	beat_t		tx_words [2048];
	// Expected frames, words and lengths in delivery order
	beat_t		exp_beats [$];
	int		exp_lens [$];
	beat_t		got_words [$];
	logic		got_open;
	int		errors;
	int		frames_sent;
	int		expected_total;
	int		delivered;
	int		cycle_count;
	int		cycle_limit = 0;

	//////////////////////
	// Clocks and DUT

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// MAC side runs a little faster than the system side
	initial begin
		rx_clk = 1'b0;
		forever #4 rx_clk = ~rx_clk;
	end

	eth_rx_cdc dut0 (
		.rx_clk			(rx_clk),
		.sys_clk		(sys_clk),
		.rst			(rst),
		.mac			(mac),
		.frame			(frame),
		.perf_rx_cdc_frames	(perf_rx_cdc_frames)
	);

	bind eth_rx_cdc eth_rx_cdc_chk chk0 (
		.sys_clk	(sys_clk),
		.rst		(rst),
		.frame		(frame)
	);

	// Uniform pick in lo..hi
	function automatic int pick(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	// Only a committed frame survives, and only if delimiter plus body fit the FIFO
	function automatic bit frame_survives(input int len, input int ending);
		return (ending == END_COMMIT) && (len + 1 <= `ETH_RX_FIFO_DEPTH);
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("error: time %0t signal %s expected %0h got %0h",
				$time, name, exp, got);
			errors++;
		end
	endtask

	//////////////////////
	// MAC side stimulus

	// New bus value 1 ns after the rx_clk edge
	task automatic drive_mac(input mac_rx_bus_t value);
		@(posedge rx_clk);
		#1;
		mac = value;
	endtask

	task automatic idle_rx(input int n);
		repeat (n) drive_mac('0);
	endtask

	// Start, body, then the ending strobe unless the next start cuts it off
	task automatic send_frame(input int ending, input int gap);
		int		len;
		mac_rx_bus_t	w;
		len = len_tab[frame_idx];
		frame_idx++;
		frames_sent++;
		// Last word carries 1 to 4 bytes, the rest are full
		for (int k = 0; k < len; k++) begin
			tx_words[k].bytes_valid	= (k == len - 1) ? 3'(pick(1, 4)) : 3'd4;
			tx_words[k].data	= $random(seed);
		end
		w = '0;
		w.start = 1'b1;
		drive_mac(w);
		for (int k = 0; k < len; k++) begin
			w = '0;
			w.data_valid	= 1'b1;
			w.bytes_valid	= tx_words[k].bytes_valid;
			w.data		= tx_words[k].data;
			drive_mac(w);
		end
		if (frame_survives(len, ending)) begin
			for (int k = 0; k < len; k++) begin
				exp_beats.push_back(tx_words[k]);
			end
			exp_lens.push_back(len);
			expected_total++;
		end
		if (ending != END_NONE) begin
			w = '0;
			w.commit	= (ending == END_COMMIT);
			w.drop		= (ending == END_DROP);
			drive_mac(w);
			idle_rx(gap);
		end
	endtask

	// Wait for all expected frames, then a while longer for stray ones
	task automatic drain();
		idle_rx(1);
		while (exp_lens.size() != 0) begin
			@(posedge sys_clk);
		end
		repeat (40) @(posedge sys_clk);
	endtask

	task automatic report_test(input string name, input int err_start);
		$display("[%0t] %s finished, %0d errors", $time, name, errors - err_start);
	endtask

	//////////////////////
	// System side compare

	// Frame just closed by commit against the head of the expected queue
	task automatic check_frame();
		int	len;
		beat_t	want;
		delivered++;
		got_open = 1'b0;
		assert (exp_lens.size() != 0) else begin
			$display("error: frame delivered at time %0t while none was expected", $time);
			errors++;
		end
		if (exp_lens.size() != 0) begin
			len = exp_lens.pop_front();
			check_value("frame length", 64'(got_words.size()), 64'(len));
			for (int k = 0; k < len; k++) begin
				want = exp_beats.pop_front();
				if (k < got_words.size()) begin
					check_value("frame.bytes_valid", 64'(got_words[k].bytes_valid),
						64'(want.bytes_valid));
					check_value("frame.data", 64'(got_words[k].data), 64'(want.data));
				end
			end
		end
	endtask

	// Sampled on the falling edge, away from the registered outputs
	initial begin : compare
		beat_t beat;
		got_open = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (!rst) begin
				if (frame.start) begin
					got_open = 1'b1;
					got_words.delete();
				end
				if (frame.data_valid && got_open) begin
					beat.bytes_valid	= frame.bytes_valid;
					beat.data		= frame.data;
					got_words.push_back(beat);
				end
				if (frame.commit) begin
					check_frame();
				end
			end
		end
	end

	// Run limit grows with the total number of words
	initial begin : watchdog
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles with %0d frames still expected",
			cycle_count, exp_lens.size());
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////
	// Test sequence

	initial begin : main
		int err_start;
		mac		= '0;
		rst		= 1'b1;
		seed		= 32'hf582_615e;
		errors		= 0;
		frame_idx	= 0;
		frames_sent	= 0;
		expected_total	= 0;
		delivered	= 0;
		for (int i = 0; i < N_FRAMES; i++) begin
			len_tab[i] = (i == BIG_IDX) ? BIG_LEN : pick(1, 64);
		end
		cycle_limit = 5000;
		for (int i = 0; i < N_FRAMES; i++) begin
			cycle_limit += 4 * len_tab[i];
		end

		repeat (16) @(posedge sys_clk);
		#1;
		rst = 1'b0;
		// rx_clk copy of reset falls two edges later
		repeat (4) @(posedge rx_clk);
		@(negedge sys_clk);
		err_start = errors;
		check_value("frame.start", 64'(frame.start), 64'd0);
		check_value("frame.data_valid", 64'(frame.data_valid), 64'd0);
		check_value("frame.commit", 64'(frame.commit), 64'd0);
		check_value("rd_en", 64'(dut0.rd_en), 64'd0);
		check_value("pop", 64'(dut0.pop), 64'd0);
		check_value("perf_rx_cdc_frames", perf_rx_cdc_frames, 64'd0);
		report_test("reset_state", err_start);

		err_start = errors;
		for (int i = 0; i < N_RAND; i++) begin
			send_frame(END_COMMIT, pick(0, 15));
		end
		drain();
		report_test("random_frames", err_start);

		// Commit, drop, cut off by the next start, commit
		err_start = errors;
		for (int i = 0; i < N_DROP; i++) begin
			case (i % 4)
				1: send_frame(END_DROP, pick(0, 7));
				2: send_frame(END_NONE, 0);
				default: send_frame(END_COMMIT, pick(0, 7));
			endcase
		end
		drain();
		report_test("dropped_frames", err_start);

		err_start = errors;
		for (int i = 0; i < N_OVF; i++) begin
			send_frame(END_COMMIT, 10);
		end
		drain();
		report_test("overflow_frame", err_start);

		err_start = errors;
		for (int i = 0; i < N_B2B; i++) begin
			send_frame(END_COMMIT, 0);
		end
		drain();
		report_test("back_to_back", err_start);

		err_start = errors;
		check_value("perf_rx_cdc_frames", perf_rx_cdc_frames, 64'(expected_total));
		check_value("frames delivered", 64'(delivered), 64'(expected_total));
		report_test("frame_counter", err_start);

		$display("frames sent %0d, expected %0d, delivered %0d, errors %0d",
			frames_sent, expected_total, delivered, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
eth_frame_pkg.sv
cdc_fifo_pkg.sv
rx_word_packer.sv
packet_cdc_fifo.sv
rx_frame_unpacker.sv
eth_rx_cdc.sv
eth_rx_cdc_chk.sv
tb_eth_rx_cdc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sim.f --top-module tb_eth_rx_cdc -o sim_tb || exit 1

out="$(./obj_dir/sim_tb)"
printf '%s\n' "$out"

# Pass only when the pass line is in the output
printf '%s\n' "$out" | grep -qx "TEST OK" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
